// ==== verilog/conv_pkg.sv ====
// convolution sizes, memory map, word and address types, channel structs, tile extent, FSM states
package conv_pkg;

    localparam int R = 12;                          // input map rows
    localparam int C = 12;                          // input map cols
    localparam int K = 3;                           // kernel size
    localparam int OR = R - K + 1;
    localparam int OC = C - K + 1;
    localparam int TOR = 4;                         // output tile rows
    localparam int TOC = 4;                         // output tile cols
    localparam int TILE_ROWS = (OR + TOR - 1) / TOR;
    localparam int TILE_COLS = (OC + TOC - 1) / TOC;
    localparam int WIN_MAX = TOR + K - 1;           // window buffer row stride
    localparam int IN_BASE = 0;
    localparam int W_BASE = 256;
    localparam int OUT_BASE = 512;

    typedef logic [31:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [7:0] cord_t;

    typedef struct packed {
        addr_t addr;
    } rd_req_t;

    typedef struct packed {
        word_t data;
    } rd_resp_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } wr_req_t;

    typedef struct packed {
        cord_t row;
        cord_t col;
    } tile_cord_t;

    typedef struct packed {
        cord_t row;                                 // absolute output row
        cord_t col;                                 // absolute output col
        word_t value;
    } mac_result_t;

    // valid output pixels along one axis, edge tiles clipped to the map
    function automatic cord_t tile_extent(input cord_t origin, input int tile, input int total);
        cord_t rem;
        rem = cord_t'(total) - origin;
        return (rem < cord_t'(tile)) ? rem : cord_t'(tile);
    endfunction

    typedef enum logic {S_IDLE, S_RUN} sched_state_t;
    typedef enum logic [1:0] {L_IDLE, L_REQ_W, L_REQ_IN, L_FULL} load_state_t;
    typedef enum logic [1:0] {M_IDLE, M_ACC, M_HOLD} mac_state_t;

endpackage

// ==== verilog/tile_sched.sv ====
// tile origin generator, tile counter and convolution start/done control
`timescale 1ns/10ps

module tile_sched (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 tile_done,
    output logic                 tile_start,
    output conv_pkg::tile_cord_t cord,
    output logic                 first_tile,
    output logic                 busy,
    output logic                 done
);
    import conv_pkg::*;

    sched_state_t state;
    logic [3:0]   tile_cnt;                         // tiles completed so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            tile_start <= 1'b0;
            done       <= 1'b0;
            first_tile <= 1'b0;
            tile_cnt   <= '0;
            cord       <= '0;
        end else begin
            tile_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    state      <= S_RUN;
                    tile_start <= 1'b1;
                    first_tile <= 1'b1;
                    tile_cnt   <= '0;
                    cord       <= '0;
                end
                S_RUN: if (tile_done) begin
                    first_tile <= 1'b0;
                    if (tile_cnt == 4'(TILE_ROWS * TILE_COLS - 1)) begin
                        state <= S_IDLE;                // last tile, finish
                        done  <= 1'b1;
                    end else begin
                        tile_cnt   <= tile_cnt + 1'b1;
                        tile_start <= 1'b1;
                        if (cord.col + cord_t'(TOC) >= cord_t'(OC)) begin
                            cord.col <= '0;             // wrap to next tile row
                            cord.row <= cord.row + cord_t'(TOR);
                        end else begin
                            cord.col <= cord.col + cord_t'(TOC);
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign busy = (state == S_RUN);

endmodule

// ==== verilog/tile_loader.sv ====
// input side, kernel and tile window fetch into local buffers
`timescale 1ns/10ps

module tile_loader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tile_start,
    input  logic                 first_tile,
    input  conv_pkg::tile_cord_t cord,
    output conv_pkg::rd_req_t    rd_req,
    output logic                 rd_req_valid,
    input  logic                 rd_req_ready,
    input  conv_pkg::rd_resp_t   rd_resp,
    input  logic                 rd_resp_valid,
    output logic                 rd_resp_ready,
    output logic                 win_full,
    input  logic                 win_release,
    output conv_pkg::word_t      kern_buf [conv_pkg::K * conv_pkg::K],
    output conv_pkg::word_t      win_buf [conv_pkg::WIN_MAX * conv_pkg::WIN_MAX]
);
    import conv_pkg::*;

    load_state_t state;
    cord_t       win_rows, win_cols;                // clipped window size
    logic [3:0]  req_k, rsp_k;                      // kernel word index
    cord_t       req_r, req_c, rsp_r, rsp_c;        // window position
    logic        req_fin;                           // all window requests sent
    logic        rsp_w;                             // responses still go to kernel buffer

    assign win_rows = tile_extent(cord.row, TOR, OR) + cord_t'(K - 1);
    assign win_cols = tile_extent(cord.col, TOC, OC) + cord_t'(K - 1);

    assign rd_req_valid  = (state == L_REQ_W) || (state == L_REQ_IN && !req_fin);
    assign rd_resp_ready = (state == L_REQ_W) || (state == L_REQ_IN);
    assign win_full      = (state == L_FULL);

    always_comb begin
        if (state == L_REQ_W)
            rd_req.addr = addr_t'(W_BASE) + addr_t'(req_k);
        else
            rd_req.addr = addr_t'(IN_BASE)
                        + (addr_t'(cord.row) + addr_t'(req_r)) * addr_t'(C)
                        + addr_t'(cord.col) + addr_t'(req_c);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= L_IDLE;
            req_k   <= '0;
            req_r   <= '0;
            req_c   <= '0;
            req_fin <= 1'b0;
            rsp_w   <= 1'b0;
            rsp_k   <= '0;
            rsp_r   <= '0;
            rsp_c   <= '0;
        end else begin
            case (state)
                L_IDLE: if (tile_start) begin
                    state   <= first_tile ? L_REQ_W : L_REQ_IN;  // weights once per run
                    rsp_w   <= first_tile;
                    req_k   <= '0;
                    req_r   <= '0;
                    req_c   <= '0;
                    req_fin <= 1'b0;
                    rsp_k   <= '0;
                    rsp_r   <= '0;
                    rsp_c   <= '0;
                end
                L_REQ_W: if (rd_req_valid && rd_req_ready) begin
                    req_k <= req_k + 1'b1;
                    if (req_k == 4'(K * K - 1))
                        state <= L_REQ_IN;
                end
                L_REQ_IN: if (rd_req_valid && rd_req_ready) begin
                    if (req_c == win_cols - 1'b1) begin
                        req_c <= '0;
                        req_r <= req_r + 1'b1;
                        if (req_r == win_rows - 1'b1)
                            req_fin <= 1'b1;
                    end else begin
                        req_c <= req_c + 1'b1;
                    end
                end
                L_FULL: if (win_release)
                    state <= L_IDLE;                    // mac done with window
                default: state <= L_IDLE;
            endcase
            // responses arrive in request order
            if (rd_resp_valid && rd_resp_ready) begin
                if (rsp_w) begin
                    rsp_k <= rsp_k + 1'b1;
                    if (rsp_k == 4'(K * K - 1))
                        rsp_w <= 1'b0;
                end else if (rsp_c == win_cols - 1'b1) begin
                    rsp_c <= '0;
                    rsp_r <= rsp_r + 1'b1;
                    if (rsp_r == win_rows - 1'b1)
                        state <= L_FULL;                // window complete
                end else begin
                    rsp_c <= rsp_c + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_resp_valid && rd_resp_ready) begin
            if (rsp_w)
                kern_buf[rsp_k] <= rd_resp.data;
            else
                win_buf[rsp_r * WIN_MAX + rsp_c] <= rd_resp.data;  // fixed stride
        end
    end

endmodule

// ==== verilog/tile_mac.sv ====
// processing part, per-pixel K*K multiply-accumulate and result stream
`timescale 1ns/10ps

module tile_mac (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_pkg::tile_cord_t  cord,
    input  logic                  win_full,
    input  conv_pkg::word_t       kern_buf [conv_pkg::K * conv_pkg::K],
    input  conv_pkg::word_t       win_buf [conv_pkg::WIN_MAX * conv_pkg::WIN_MAX],
    output logic                  win_release,
    output conv_pkg::mac_result_t res,
    output logic                  res_valid,
    input  logic                  res_ready
);
    import conv_pkg::*;

    mac_state_t state;
    cord_t      ext_r, ext_c;                       // clipped tile size
    cord_t      pr, pc;                             // pixel within tile
    cord_t      kr, kc;                             // kernel position
    word_t      acc;
    word_t      prod;
    logic       last_k, last_pix;

    assign ext_r    = tile_extent(cord.row, TOR, OR);
    assign ext_c    = tile_extent(cord.col, TOC, OC);
    assign last_k   = (kr == cord_t'(K - 1)) && (kc == cord_t'(K - 1));
    assign last_pix = (pr == ext_r - 1'b1) && (pc == ext_c - 1'b1);

    // low 32 bits of the signed product
    assign prod = word_t'($signed(win_buf[(pr + kr) * WIN_MAX + pc + kc])
                        * $signed(kern_buf[kr * K + kc]));

    assign res_valid   = (state == M_HOLD);
    assign win_release = (state == M_ACC) && last_k && last_pix;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= M_IDLE;
            pr    <= '0;
            pc    <= '0;
            kr    <= '0;
            kc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                M_IDLE: if (win_full) begin
                    state <= M_ACC;
                    pr    <= '0;
                    pc    <= '0;
                    kr    <= '0;
                    kc    <= '0;
                    acc   <= '0;
                end
                M_ACC: begin
                    if (last_k) begin
                        acc   <= '0;
                        kr    <= '0;
                        kc    <= '0;
                        state <= M_HOLD;
                    end else begin
                        acc <= acc + prod;
                        if (kc == cord_t'(K - 1)) begin
                            kc <= '0;
                            kr <= kr + 1'b1;
                        end else begin
                            kc <= kc + 1'b1;
                        end
                    end
                end
                M_HOLD: if (res_ready) begin
                    state <= last_pix ? M_IDLE : M_ACC;  // next pixel after accept
                    if (pc == ext_c - 1'b1) begin
                        pc <= '0;
                        pr <= pr + 1'b1;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_ACC && last_k) begin
            res.value <= acc + prod;
            res.row   <= cord.row + pr;
            res.col   <= cord.col + pc;
        end
    end

endmodule

// ==== verilog/tile_writer.sv ====
// output side, write address generation, write register and tile completion
`timescale 1ns/10ps

module tile_writer (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_pkg::tile_cord_t  cord,
    input  conv_pkg::mac_result_t res,
    input  logic                  res_valid,
    output logic                  res_ready,
    output conv_pkg::wr_req_t     wr_req,
    output logic                  wr_valid,
    input  logic                  wr_ready,
    output logic                  tile_done
);
    import conv_pkg::*;

    logic [4:0] wr_cnt;                             // accepted writes this tile
    logic [4:0] pix_total;

    assign pix_total = 5'(tile_extent(cord.row, TOR, OR) * tile_extent(cord.col, TOC, OC));
    assign res_ready = !wr_valid || wr_ready;       // stage empty or draining

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_valid  <= 1'b0;
            wr_cnt    <= '0;
            tile_done <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            if (res_valid && res_ready)
                wr_valid <= 1'b1;
            else if (wr_ready)
                wr_valid <= 1'b0;
            if (wr_valid && wr_ready) begin
                if (wr_cnt == pix_total - 1'b1) begin
                    wr_cnt    <= '0;
                    tile_done <= 1'b1;              // last pixel of the tile
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            wr_req.addr <= addr_t'(OUT_BASE) + addr_t'(res.row) * addr_t'(OC)
                         + addr_t'(res.col);
            wr_req.data <= res.value;
        end
    end

endmodule

// ==== verilog/conv_top.sv ====
// convolution engine top, scheduler, loader, mac and writer
`timescale 1ns/10ps

module conv_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    output logic                done,
    output logic                busy,
    output conv_pkg::rd_req_t   rd_req,
    output logic                rd_req_valid,
    input  logic                rd_req_ready,
    input  conv_pkg::rd_resp_t  rd_resp,
    input  logic                rd_resp_valid,
    output logic                rd_resp_ready,
    output conv_pkg::wr_req_t   wr_req,
    output logic                wr_valid,
    input  logic                wr_ready
);
    import conv_pkg::*;

    logic        tile_start, tile_done, first_tile;
    tile_cord_t  cord;
    logic        win_full, win_release;
    word_t       kern_buf [K * K];
    word_t       win_buf [WIN_MAX * WIN_MAX];
    mac_result_t res;
    logic        res_valid, res_ready;

    tile_sched u_sched (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .tile_done  (tile_done),
        .tile_start (tile_start),
        .cord       (cord),
        .first_tile (first_tile),
        .busy       (busy),
        .done       (done)
    );

    tile_loader u_loader (
        .clk           (clk),
        .rst           (rst),
        .tile_start    (tile_start),
        .first_tile    (first_tile),
        .cord          (cord),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready),
        .win_full      (win_full),
        .win_release   (win_release),
        .kern_buf      (kern_buf),
        .win_buf       (win_buf)
    );

    tile_mac u_mac (
        .clk         (clk),
        .rst         (rst),
        .cord        (cord),
        .win_full    (win_full),
        .kern_buf    (kern_buf),
        .win_buf     (win_buf),
        .win_release (win_release),
        .res         (res),
        .res_valid   (res_valid),
        .res_ready   (res_ready)
    );

    tile_writer u_writer (
        .clk       (clk),
        .rst       (rst),
        .cord      (cord),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .wr_req    (wr_req),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .tile_done (tile_done)
    );

endmodule

// ==== sim/conv_properties.sv ====
// bound checks on idle outputs, valid/ready stability, write address range and done pulse
`timescale 1ns/10ps

module conv_properties (
    input logic                clk,
    input logic                rst,
    input logic                start,
    input logic                done,
    input logic                busy,
    input conv_pkg::rd_req_t   rd_req,
    input logic                rd_req_valid,
    input logic                rd_req_ready,
    input conv_pkg::rd_resp_t  rd_resp,
    input logic                rd_resp_valid,
    input logic                rd_resp_ready,
    input conv_pkg::wr_req_t   wr_req,
    input logic                wr_valid,
    input logic                wr_ready
);
    import conv_pkg::*;

    logic started;                                  // first start seen since reset
    int   fail_count = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            started <= 1'b0;
        else if (start)
            started <= 1'b1;
    end

    idle_before_start: assert property (@(posedge clk) disable iff (rst)
        !started |-> !rd_req_valid && !wr_valid && !busy && !done)
        else begin
            $error("engine active before the first start");
            fail_count++;
        end

    rd_req_hold: assert property (@(posedge clk) disable iff (rst)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
        else begin
            $error("read request changed while stalled");
            fail_count++;
        end

    rd_resp_hold: assert property (@(posedge clk) disable iff (rst)
        rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp))
        else begin
            $error("read response changed while stalled");
            fail_count++;
        end

    wr_hold: assert property (@(posedge clk) disable iff (rst)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_req))
        else begin
            $error("write request changed while stalled");
            fail_count++;
        end

    wr_addr_range: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> wr_req.addr >= addr_t'(OUT_BASE) && wr_req.addr < addr_t'(OUT_BASE + OR * OC))
        else begin
            $error("write address outside the output map");
            fail_count++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy ##1 !done)
        else begin
            $error("done is not a single pulse with busy low");
            fail_count++;
        end

endmodule

bind conv_top conv_properties props (.*);

// ==== sim/conv_tb.sv ====
// testbench for conv_top with memory model, random back-pressure and reference convolution
`timescale 1ns/10ps

module conv_tb;
    import conv_pkg::*;

    logic     clk, rst, start, done, busy;
    rd_req_t  rd_req;
    logic     rd_req_valid, rd_req_ready;
    rd_resp_t rd_resp;
    logic     rd_resp_valid, rd_resp_ready;
    wr_req_t  wr_req;
    logic     wr_valid, wr_ready;

    word_t  mem [1024];
    word_t  resp_q [$];                             // read data in request order
    logic   resp_taken;                             // front response accepted at next edge
    int     expect_val [OR * OC];
    int     wr_seen [OR * OC];
    int     wr_total;
    int     done_seen;
    int     runs;
    integer seed = 71;

    conv_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // random value in -8..7
    function automatic word_t small_value();
        return word_t'(($random(seed) & 15) - 8);
    endfunction

    task automatic fill_memory();
        for (int a = 0; a < 1024; a++)
            mem[a] = 32'h5a5a_0000 | a;             // untouched words show their own address
        for (int i = 0; i < R * C; i++)
            mem[IN_BASE + i] = small_value();
        for (int i = 0; i < K * K; i++)
            mem[W_BASE + i] = small_value();
    endtask

    task automatic compute_reference();
        int acc;
        for (int r = 0; r < OR; r++) begin
            for (int c = 0; c < OC; c++) begin
                acc = 0;
                for (int i = 0; i < K; i++)
                    for (int j = 0; j < K; j++)
                        acc += $signed(mem[IN_BASE + (r + i) * C + c + j])
                             * $signed(mem[W_BASE + i * K + j]);
                expect_val[r * OC + c] = acc;
            end
        end
    endtask

    task automatic check_write(input addr_t addr, input word_t data);
        int idx;
        idx = int'(addr) - OUT_BASE;
        assert (idx >= 0 && idx < OR * OC)
            else stop_with_error($sformatf("error at %0t: wr_req.addr is %0d, expected %0d..%0d",
                $time, addr, OUT_BASE, OUT_BASE + OR * OC - 1));
        assert ($signed(data) == expect_val[idx])
            else stop_with_error($sformatf("error at %0t: wr_req.data at %0d is %0d, expected %0d",
                $time, addr, $signed(data), expect_val[idx]));
        assert (wr_seen[idx] == 0)
            else stop_with_error($sformatf("output address %0d written twice in one run", addr));
        wr_seen[idx]++;
        wr_total++;
        mem[addr] = data;
    endtask

    // memory model driving on the falling edge
    initial begin
        rd_req_ready  = 1'b0;
        rd_resp_valid = 1'b0;
        rd_resp       = '0;
        wr_ready      = 1'b0;
        resp_taken    = 1'b0;
        forever begin
            @(negedge clk);
            if (resp_taken) begin
                void'(resp_q.pop_front());
                rd_resp_valid = 1'b0;
            end
            if (rst) begin
                rd_req_ready = 1'b0;
                wr_ready     = 1'b0;
            end else begin
                rd_req_ready = ($random(seed) % 3) != 0;   // stall about a third of cycles
                wr_ready     = ($random(seed) % 3) != 0;
                if (!rd_resp_valid && resp_q.size() > 0 && ($random(seed) % 3) != 0) begin
                    rd_resp_valid = 1'b1;
                    rd_resp.data  = resp_q[0];
                end
            end
            #1;                                     // sample after inputs settle
            resp_taken = rd_resp_valid && rd_resp_ready;
            if (rd_req_valid && rd_req_ready)
                resp_q.push_back(mem[rd_req.addr]);
            if (wr_valid && wr_ready)
                check_write(wr_req.addr, wr_req.data);
        end
    end

    always @(negedge clk)
        if (!rst && done)
            done_seen++;

    always @(negedge clk)
        if (dut.props.fail_count != 0)
            stop_with_error("a bound protocol assertion failed");

    task automatic run_convolution();
        int cycles;
        wr_total = 0;
        foreach (wr_seen[i])
            wr_seen[i] = 0;
        runs++;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (!done) begin
            if (cycles == 20000)
                stop_with_error("timeout, done did not come within 20000 cycles");
            assert (busy)
                else stop_with_error($sformatf("error at %0t: busy is %0b, expected 1",
                    $time, busy));
            start = (cycles == 20);                 // extra start while busy
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        assert (!busy)
            else stop_with_error($sformatf("error at %0t: busy is %0b, expected 0", $time, busy));
        assert (wr_total == OR * OC)
            else stop_with_error($sformatf("error at %0t: write count is %0d, expected %0d",
                $time, wr_total, OR * OC));
        foreach (wr_seen[i])
            assert (wr_seen[i] == 1)
                else stop_with_error($sformatf("output address %0d was never written",
                    OUT_BASE + i));
        repeat (40) begin
            @(negedge clk);
            assert (!busy && !done)
                else stop_with_error("engine became active again after done");
        end
        assert (done_seen == runs)
            else stop_with_error($sformatf("error at %0t: done count is %0d, expected %0d",
                $time, done_seen, runs));
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        runs      = 0;
        done_seen = 0;
        fill_memory();
        compute_reference();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);                  // idle window before the first start
        run_convolution();
        fill_memory();                              // new inputs and new weights
        compute_reference();
        run_convolution();
        if (dut.props.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_error("bound protocol assertions reported failures");
        end
    end

endmodule

// ==== sim.f ====
verilog/conv_pkg.sv
verilog/tile_sched.sv
verilog/tile_loader.sv
verilog/tile_mac.sv
verilog/tile_writer.sv
verilog/conv_top.sv
sim/conv_properties.sv
sim/conv_tb.sv

// ==== Makefile ====
# Verilator build and run of the convolution testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f sim.f -o conv_sim
	./obj_dir/conv_sim > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "TEST FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
